/* logic/axi_mem_array.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_array #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                                  clock,
    input  logic                                  wr_en,
    input  logic [axi_mem_pkg::ADDR_WIDTH-4:0]    wr_index,
    input  logic [axi_mem_pkg::STRB_WIDTH-1:0]    wr_strb,
    input  axi_mem_pkg::axi_beat_u                wr_data,
    input  logic                                  rd_en,
    input  logic [axi_mem_pkg::ADDR_WIDTH-4:0]    rd_index,
    output axi_mem_pkg::axi_beat_u                rd_data
);
    import axi_mem_pkg::*;

    axi_beat_u mem [MEM_WORDS];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_index % MEM_WORDS].bytes[b] <= wr_data.bytes[b];
                end
            end
        end
        if (rd_en) begin
            rd_data <= mem[rd_index % MEM_WORDS]; // held until the next fetch
        end
    end

endmodule

`default_nettype wire

/* logic/axi_mem_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_cfg #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  cfg_awvalid,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]    cfg_awaddr,
    output logic                                  cfg_awready,
    input  logic                                  cfg_wvalid,
    input  logic [31:0]                           cfg_wdata,
    output logic                                  cfg_wready,
    output logic                                  cfg_bvalid,
    output logic [1:0]                            cfg_bresp,
    input  logic                                  cfg_bready,
    input  logic                                  cfg_arvalid,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]    cfg_araddr,
    output logic                                  cfg_arready,
    output logic                                  cfg_rvalid,
    output logic [31:0]                           cfg_rdata,
    output logic [1:0]                            cfg_rresp,
    input  logic                                  cfg_rready,
    input  logic                                  wr_refused,
    input  logic                                  rd_refused,
    output logic [axi_mem_pkg::ADDR_WIDTH-1:0]    limit,
    output logic [axi_mem_pkg::WAIT_WIDTH-1:0]    rd_wait
);
    import axi_mem_pkg::*;

    logic        live;
    logic [15:0] err_count;
    logic [16:0] err_sum;
    logic        w_take;
    logic        r_take;

    assign cfg_awready = live & ~cfg_bvalid;
    assign cfg_wready  = live & ~cfg_bvalid;
    assign cfg_arready = live & ~cfg_rvalid;
    assign w_take      = cfg_awvalid & cfg_wvalid & cfg_awready;
    assign r_take      = cfg_arvalid & cfg_arready;
    assign err_sum     = {1'b0, err_count} + 17'(wr_refused) + 17'(rd_refused);

    always_ff @(posedge clock) begin
        if (reset) begin
            live       <= 1'b0;
            cfg_bvalid <= 1'b0;
            cfg_rvalid <= 1'b0;
            limit      <= ADDR_WIDTH'(MEM_WORDS * 8 - 1);
            rd_wait    <= '0;
            err_count  <= '0;
        end else begin
            live <= 1'b1; // ready lines come up after reset
            if (w_take) begin
                cfg_bvalid <= 1'b1;
            end else if (cfg_bready) begin
                cfg_bvalid <= 1'b0;
            end
            if (r_take) begin
                cfg_rvalid <= 1'b1;
            end else if (cfg_rready) begin
                cfg_rvalid <= 1'b0;
            end
            if (w_take && cfg_awaddr == REG_LIMIT) begin
                limit <= cfg_wdata;
            end
            if (w_take && cfg_awaddr == REG_RD_WAIT) begin
                rd_wait <= cfg_wdata[WAIT_WIDTH-1:0];
            end
            if (w_take && cfg_awaddr == REG_ERR_COUNT) begin
                err_count <= '0; // any write clears
            end else begin
                err_count <= err_sum[16] ? 16'hffff : err_sum[15:0]; // saturate
            end
        end
    end

    always_ff @(posedge clock) begin
        if (w_take) begin
            cfg_bresp <= (cfg_awaddr == REG_LIMIT || cfg_awaddr == REG_RD_WAIT ||
                          cfg_awaddr == REG_ERR_COUNT) ? RESP_OKAY : RESP_SLVERR;
        end
        if (r_take) begin
            cfg_rresp <= RESP_OKAY;
            case (cfg_araddr)
                REG_LIMIT:     cfg_rdata <= limit;
                REG_RD_WAIT:   cfg_rdata <= 32'(rd_wait);
                REG_ERR_COUNT: cfg_rdata <= {16'd0, err_count};
                default: begin
                    cfg_rdata <= '0; // unmapped
                    cfg_rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/axi_mem_pkg.sv */
`default_nettype none

package axi_mem_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int ID_WIDTH   = 4;
    localparam int WAIT_WIDTH = 4;

    // one beat, seen whole or byte by byte
    typedef union packed {
        logic [DATA_WIDTH-1:0]       word;
        logic [STRB_WIDTH-1:0][7:0]  bytes;
    } axi_beat_u;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    localparam logic [ADDR_WIDTH-1:0] REG_LIMIT     = 'h0;
    localparam logic [ADDR_WIDTH-1:0] REG_RD_WAIT   = 'h4;
    localparam logic [ADDR_WIDTH-1:0] REG_ERR_COUNT = 'h8;

endpackage

`default_nettype wire

/* logic/axi_mem_read.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_read (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  s_axi_arvalid,
    input  logic [axi_mem_pkg::ID_WIDTH-1:0]      s_axi_arid,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]    s_axi_araddr,
    input  logic [7:0]                            s_axi_arlen,
    input  logic [1:0]                            s_axi_arburst, // always run as INCR
    output logic                                  s_axi_arready,
    input  logic                                  s_axi_rready,
    output logic                                  s_axi_rvalid,
    output logic [axi_mem_pkg::ID_WIDTH-1:0]      s_axi_rid,
    output logic [axi_mem_pkg::DATA_WIDTH-1:0]    s_axi_rdata,
    output logic [1:0]                            s_axi_rresp,
    output logic                                  s_axi_rlast,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]    limit,
    input  logic [axi_mem_pkg::WAIT_WIDTH-1:0]    rd_wait,
    output logic                                  refused,
    output logic                                  rd_en,
    output logic [axi_mem_pkg::ADDR_WIDTH-4:0]    rd_index,
    input  axi_mem_pkg::axi_beat_u                rd_data
);
    import axi_mem_pkg::*;

    localparam logic [2:0] R_INIT  = 3'd0;
    localparam logic [2:0] R_IDLE  = 3'd1;
    localparam logic [2:0] R_WAIT  = 3'd2;
    localparam logic [2:0] R_FETCH = 3'd3;
    localparam logic [2:0] R_BEAT  = 3'd4;

    logic [2:0]            state;
    logic [ID_WIDTH-1:0]   id_q;
    logic [ADDR_WIDTH-4:0] index_q;
    logic [7:0]            len_q;
    logic [7:0]            beat_q;
    logic [WAIT_WIDTH-1:0] wait_q;
    logic [WAIT_WIDTH-1:0] wait_cnt;
    logic                  refused_q;
    logic [ADDR_WIDTH:0]   last_byte;
    logic                  ar_hs;
    logic                  r_hs;

    assign last_byte = {1'b0, s_axi_araddr} +
                       {{(ADDR_WIDTH-10){1'b0}}, s_axi_arlen, 3'b111};

    assign s_axi_arready = (state == R_IDLE);
    assign s_axi_rvalid  = (state == R_BEAT);
    assign s_axi_rlast   = (state == R_BEAT) && (beat_q == len_q);
    assign s_axi_rid     = id_q;
    assign s_axi_rresp   = refused_q ? RESP_DECERR : RESP_OKAY;
    assign s_axi_rdata   = refused_q ? '0 : rd_data.word; // array output holds while stalled
    assign ar_hs         = s_axi_arvalid & s_axi_arready;
    assign r_hs          = s_axi_rvalid & s_axi_rready;
    assign refused       = ar_hs && (last_byte > {1'b0, limit});
    assign rd_en         = (state == R_FETCH) & ~refused_q;
    assign rd_index      = index_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= R_INIT;
        end else begin
            case (state)
                R_INIT: state <= R_IDLE;
                R_IDLE: begin
                    if (ar_hs) begin
                        state <= (rd_wait == '0) ? R_FETCH : R_WAIT;
                    end
                end
                R_WAIT: if (wait_cnt == 1) state <= R_FETCH;
                R_FETCH: state <= R_BEAT;
                R_BEAT: begin
                    if (r_hs) begin
                        if (beat_q == len_q) begin
                            state <= R_IDLE;
                        end else begin
                            state <= (wait_q == '0) ? R_FETCH : R_WAIT;
                        end
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (ar_hs) begin
            id_q      <= s_axi_arid;
            index_q   <= s_axi_araddr[ADDR_WIDTH-1:3];
            len_q     <= s_axi_arlen;
            beat_q    <= '0;
            wait_q    <= rd_wait; // fixed for the whole burst
            wait_cnt  <= rd_wait;
            refused_q <= refused;
        end else if (state == R_WAIT) begin
            wait_cnt <= wait_cnt - 1'b1;
        end else if (r_hs) begin
            beat_q   <= beat_q + 1'b1;
            index_q  <= index_q + 1'b1;
            wait_cnt <= wait_q;
        end
    end

endmodule

`default_nettype wire

/* logic/axi_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  s_axi_awvalid,
    output logic                                  s_axi_awready,
    input  logic [axi_mem_pkg::ID_WIDTH-1:0]      s_axi_awid,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]    s_axi_awaddr,
    input  logic [7:0]                            s_axi_awlen,
    input  logic [1:0]                            s_axi_awburst,
    input  logic                                  s_axi_wvalid,
    output logic                                  s_axi_wready,
    input  logic [axi_mem_pkg::DATA_WIDTH-1:0]    s_axi_wdata,
    input  logic [axi_mem_pkg::STRB_WIDTH-1:0]    s_axi_wstrb,
    input  logic                                  s_axi_wlast,
    output logic                                  s_axi_bvalid,
    input  logic                                  s_axi_bready,
    output logic [axi_mem_pkg::ID_WIDTH-1:0]      s_axi_bid,
    output logic [1:0]                            s_axi_bresp,
    input  logic                                  s_axi_arvalid,
    output logic                                  s_axi_arready,
    input  logic [axi_mem_pkg::ID_WIDTH-1:0]      s_axi_arid,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]    s_axi_araddr,
    input  logic [7:0]                            s_axi_arlen,
    input  logic [1:0]                            s_axi_arburst,
    output logic                                  s_axi_rvalid,
    input  logic                                  s_axi_rready,
    output logic [axi_mem_pkg::ID_WIDTH-1:0]      s_axi_rid,
    output logic [axi_mem_pkg::DATA_WIDTH-1:0]    s_axi_rdata,
    output logic [1:0]                            s_axi_rresp,
    output logic                                  s_axi_rlast,
    input  logic                                  cfg_awvalid,
    output logic                                  cfg_awready,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]    cfg_awaddr,
    input  logic                                  cfg_wvalid,
    output logic                                  cfg_wready,
    input  logic [31:0]                           cfg_wdata,
    output logic                                  cfg_bvalid,
    input  logic                                  cfg_bready,
    output logic [1:0]                            cfg_bresp,
    input  logic                                  cfg_arvalid,
    output logic                                  cfg_arready,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]    cfg_araddr,
    output logic                                  cfg_rvalid,
    input  logic                                  cfg_rready,
    output logic [31:0]                           cfg_rdata,
    output logic [1:0]                            cfg_rresp
);
    import axi_mem_pkg::*;

    logic [ADDR_WIDTH-1:0] limit;
    logic [WAIT_WIDTH-1:0] rd_wait;
    logic                  wr_refused;
    logic                  rd_refused;
    logic                  wr_en;
    logic [ADDR_WIDTH-4:0] wr_index;
    logic [STRB_WIDTH-1:0] wr_strb;
    axi_beat_u             wr_data;
    logic                  rd_en;
    logic [ADDR_WIDTH-4:0] rd_index;
    axi_beat_u             rd_data;

    axi_mem_cfg #(.MEM_WORDS(MEM_WORDS)) axi_mem_cfg_inst (.*);

    axi_mem_write axi_mem_write_inst (
        .refused (wr_refused),
        .*
    );

    axi_mem_read axi_mem_read_inst (
        .refused (rd_refused),
        .*
    );

    axi_mem_array #(.MEM_WORDS(MEM_WORDS)) axi_mem_array_inst (.*);

endmodule

`default_nettype wire

/* logic/axi_mem_write.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_write (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  s_axi_awvalid,
    input  logic [axi_mem_pkg::ID_WIDTH-1:0]      s_axi_awid,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]    s_axi_awaddr,
    input  logic [7:0]                            s_axi_awlen,
    input  logic [1:0]                            s_axi_awburst, // always run as INCR
    output logic                                  s_axi_awready,
    input  logic                                  s_axi_wvalid,
    input  logic [axi_mem_pkg::DATA_WIDTH-1:0]    s_axi_wdata,
    input  logic [axi_mem_pkg::STRB_WIDTH-1:0]    s_axi_wstrb,
    input  logic                                  s_axi_wlast,
    output logic                                  s_axi_wready,
    input  logic                                  s_axi_bready,
    output logic                                  s_axi_bvalid,
    output logic [axi_mem_pkg::ID_WIDTH-1:0]      s_axi_bid,
    output logic [1:0]                            s_axi_bresp,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]    limit,
    output logic                                  refused,
    output logic                                  wr_en,
    output logic [axi_mem_pkg::ADDR_WIDTH-4:0]    wr_index,
    output logic [axi_mem_pkg::STRB_WIDTH-1:0]    wr_strb,
    output axi_mem_pkg::axi_beat_u                wr_data
);
    import axi_mem_pkg::*;

    localparam logic [1:0] W_INIT = 2'd0;
    localparam logic [1:0] W_IDLE = 2'd1;
    localparam logic [1:0] W_DATA = 2'd2;
    localparam logic [1:0] W_RESP = 2'd3;

    logic [1:0]            state;
    logic [ID_WIDTH-1:0]   id_q;
    logic [ADDR_WIDTH-4:0] index_q;
    logic                  refused_q;
    logic [ADDR_WIDTH:0]   last_byte;
    logic                  aw_hs;
    logic                  w_hs;

    // start + len*8 + 7, one extra bit so a wrap counts as over
    assign last_byte = {1'b0, s_axi_awaddr} +
                       {{(ADDR_WIDTH-10){1'b0}}, s_axi_awlen, 3'b111};

    assign s_axi_awready = (state == W_IDLE);
    assign s_axi_wready  = (state == W_DATA);
    assign s_axi_bvalid  = (state == W_RESP);
    assign s_axi_bid     = id_q;
    assign s_axi_bresp   = refused_q ? RESP_DECERR : RESP_OKAY;
    assign aw_hs         = s_axi_awvalid & s_axi_awready;
    assign w_hs          = s_axi_wvalid & s_axi_wready;
    assign refused       = aw_hs && (last_byte > {1'b0, limit});

    assign wr_en        = w_hs & ~refused_q;
    assign wr_index     = index_q;
    assign wr_strb      = s_axi_wstrb;
    assign wr_data.word = s_axi_wdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= W_INIT;
        end else begin
            case (state)
                W_INIT: state <= W_IDLE;
                W_IDLE: if (aw_hs) state <= W_DATA;
                W_DATA: if (w_hs && s_axi_wlast) state <= W_RESP;
                W_RESP: if (s_axi_bready) state <= W_IDLE;
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_hs) begin
            id_q      <= s_axi_awid;
            index_q   <= s_axi_awaddr[ADDR_WIDTH-1:3];
            refused_q <= refused;
        end else if (w_hs) begin
            index_q <= index_q + 1'b1; // next word of the burst
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the AXI memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module axi_mem_tb -f verilog.f -o axi_mem_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/axi_mem_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

/* test/axi_mem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_properties (
    input logic                               clock,
    input logic                               reset,
    input logic                               s_axi_awready,
    input logic                               s_axi_wready,
    input logic                               s_axi_bvalid,
    input logic                               s_axi_bready,
    input logic [axi_mem_pkg::ID_WIDTH-1:0]   s_axi_bid,
    input logic [1:0]                         s_axi_bresp,
    input logic                               s_axi_arready,
    input logic                               s_axi_rvalid,
    input logic                               s_axi_rready,
    input logic [axi_mem_pkg::ID_WIDTH-1:0]   s_axi_rid,
    input logic [axi_mem_pkg::DATA_WIDTH-1:0] s_axi_rdata,
    input logic [1:0]                         s_axi_rresp,
    input logic                               s_axi_rlast,
    input logic                               cfg_awready,
    input logic                               cfg_wready,
    input logic                               cfg_bvalid,
    input logic                               cfg_arready,
    input logic                               cfg_rvalid
);

    read_hold: assert property (@(posedge clock) disable iff (reset)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata) &&
            $stable(s_axi_rid) && $stable(s_axi_rresp) && $stable(s_axi_rlast))
        else $error("read beat changed or dropped before rready");

    resp_hold: assert property (@(posedge clock) disable iff (reset)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp) &&
            $stable(s_axi_bid))
        else $error("write response changed or dropped before bready");

    // rlast marks the beat that closes the burst
    last_ends_burst: assert property (@(posedge clock) disable iff (reset)
        s_axi_rvalid && s_axi_rready && s_axi_rlast |=> !s_axi_rvalid && s_axi_arready)
        else $error("read engine not idle after the beat with rlast");

    // outputs settle one edge into reset
    quiet_in_reset: assert property (@(posedge clock)
        $past(reset) |-> !(s_axi_awready || s_axi_wready || s_axi_bvalid || s_axi_arready ||
            s_axi_rvalid || cfg_awready || cfg_wready || cfg_bvalid || cfg_arready ||
            cfg_rvalid))
        else $error("ready or valid output high during reset");

endmodule

bind axi_mem_top axi_mem_properties axi_mem_properties_inst (.*);

`default_nettype wire

/* test/axi_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_tb;
    import axi_mem_pkg::*;

    localparam int MEM_WORDS      = 256;
    localparam int NUM_BURSTS     = 80;
    localparam int TIMEOUT_CYCLES = NUM_BURSTS * 16 * 32 + 2000; // beats x (1 + wait + stalls)
    localparam logic [31:0] LIMIT_RESET = MEM_WORDS * 8 - 1;

    logic                  clock;
    logic                  reset;
    logic                  s_axi_awvalid;
    logic                  s_axi_awready;
    logic [ID_WIDTH-1:0]   s_axi_awid;
    logic [ADDR_WIDTH-1:0] s_axi_awaddr;
    logic [7:0]            s_axi_awlen;
    logic [1:0]            s_axi_awburst;
    logic                  s_axi_wvalid;
    logic                  s_axi_wready;
    logic [DATA_WIDTH-1:0] s_axi_wdata;
    logic [STRB_WIDTH-1:0] s_axi_wstrb;
    logic                  s_axi_wlast;
    logic                  s_axi_bvalid;
    logic                  s_axi_bready;
    logic [ID_WIDTH-1:0]   s_axi_bid;
    logic [1:0]            s_axi_bresp;
    logic                  s_axi_arvalid;
    logic                  s_axi_arready;
    logic [ID_WIDTH-1:0]   s_axi_arid;
    logic [ADDR_WIDTH-1:0] s_axi_araddr;
    logic [7:0]            s_axi_arlen;
    logic [1:0]            s_axi_arburst;
    logic                  s_axi_rvalid;
    logic                  s_axi_rready;
    logic [ID_WIDTH-1:0]   s_axi_rid;
    logic [DATA_WIDTH-1:0] s_axi_rdata;
    logic [1:0]            s_axi_rresp;
    logic                  s_axi_rlast;
    logic                  cfg_awvalid;
    logic                  cfg_awready;
    logic [ADDR_WIDTH-1:0] cfg_awaddr;
    logic                  cfg_wvalid;
    logic                  cfg_wready;
    logic [31:0]           cfg_wdata;
    logic                  cfg_bvalid;
    logic                  cfg_bready;
    logic [1:0]            cfg_bresp;
    logic                  cfg_arvalid;
    logic                  cfg_arready;
    logic [ADDR_WIDTH-1:0] cfg_araddr;
    logic                  cfg_rvalid;
    logic                  cfg_rready;
    logic [31:0]           cfg_rdata;
    logic [1:0]            cfg_rresp;

    logic [7:0]  model_mem [MEM_WORDS*8]; // byte image of the array
    logic [31:0] model_limit;
    logic [3:0]  model_wait;
    int          model_errs;
    logic [31:0] lcg_state;
    bit          stall_en;
    int          error_count;
    int          check_count;
    int          test_errors;
    int          tests_done;
    int          cycle_count;
    int          burst_word [8];
    int          burst_len [8];

    axi_mem_top #(.MEM_WORDS(MEM_WORDS)) axi_mem_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a handshake never completed", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() >> 8) % n; // low bits of an LCG repeat too soon
    endfunction

    function automatic logic pick_ready();
        if (!stall_en) begin
            return 1'b1;
        end
        return rand_below(4) != 0;
    endfunction

    // last byte = start + (len+1)*8 - 1
    function automatic bit crosses_limit(input logic [31:0] addr, input logic [7:0] len);
        logic [33:0] last;
        last = 34'(addr) + (34'(len) + 34'd1) * 34'd8 - 34'd1;
        return last > 34'(model_limit);
    endfunction

    function automatic logic [63:0] model_word(input int index);
        logic [63:0] w;
        int base;
        base = (index % MEM_WORDS) * 8;
        for (int b = 0; b < 8; b++) begin
            w[b*8 +: 8] = model_mem[base + b];
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        @(negedge clock);
        cfg_awvalid = 1'b1;
        cfg_awaddr  = addr;
        cfg_wvalid  = 1'b1;
        cfg_wdata   = data;
        while (!(cfg_awready && cfg_wready)) @(negedge clock);
        @(negedge clock);
        cfg_awvalid = 1'b0;
        cfg_wvalid  = 1'b0;
        cfg_bready  = 1'b1;
        while (!cfg_bvalid) @(negedge clock);
        check_value("cfg_bresp", 64'(cfg_bresp), 64'(exp_resp));
        @(negedge clock);
        cfg_bready = 1'b0;
    endtask

    task automatic cfg_read(input logic [31:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        @(negedge clock);
        cfg_arvalid = 1'b1;
        cfg_araddr  = addr;
        while (!cfg_arready) @(negedge clock);
        @(negedge clock);
        cfg_arvalid = 1'b0;
        cfg_rready  = 1'b1;
        while (!cfg_rvalid) @(negedge clock);
        check_value("cfg_rdata", 64'(cfg_rdata), 64'(exp_data));
        check_value("cfg_rresp", 64'(cfg_rresp), 64'(exp_resp));
        @(negedge clock);
        cfg_rready = 1'b0;
    endtask

    task automatic write_burst(input int word, input int len, input bit full_strb);
        logic [3:0]  id;
        logic [63:0] data;
        logic [7:0]  strb;
        bit          refuse;
        int          index;
        id     = 4'(rand_below(16));
        refuse = crosses_limit(32'(word * 8), 8'(len));
        @(negedge clock);
        s_axi_awvalid = 1'b1;
        s_axi_awid    = id;
        s_axi_awaddr  = 32'(word * 8);
        s_axi_awlen   = 8'(len);
        s_axi_awburst = 2'b01;
        while (!s_axi_awready) @(negedge clock);
        @(negedge clock);
        s_axi_awvalid = 1'b0;
        for (int beat = 0; beat <= len; beat++) begin
            data = {next_rand(), next_rand()};
            strb = full_strb ? 8'hff : 8'(rand_below(256));
            s_axi_wvalid = 1'b1;
            s_axi_wdata  = data;
            s_axi_wstrb  = strb;
            s_axi_wlast  = (beat == len);
            while (!s_axi_wready) @(negedge clock);
            index = (word + beat) % MEM_WORDS;
            for (int b = 0; b < 8; b++) begin
                if (strb[b] && !refuse) begin
                    model_mem[index*8 + b] = data[b*8 +: 8];
                end
            end
            @(negedge clock);
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;
        s_axi_bready = pick_ready();
        while (!(s_axi_bvalid && s_axi_bready)) begin
            @(negedge clock);
            s_axi_bready = pick_ready();
        end
        check_value("s_axi_bresp", 64'(s_axi_bresp), refuse ? 64'(RESP_DECERR) : 64'(RESP_OKAY));
        check_value("s_axi_bid", 64'(s_axi_bid), 64'(id));
        if (refuse) begin
            model_errs++;
        end
        @(negedge clock);
        s_axi_bready = 1'b0;
    endtask

    task automatic read_burst(input int word, input int len);
        logic [3:0] id;
        bit         refuse;
        int         beat;
        id     = 4'(rand_below(16));
        refuse = crosses_limit(32'(word * 8), 8'(len));
        @(negedge clock);
        s_axi_arvalid = 1'b1;
        s_axi_arid    = id;
        s_axi_araddr  = 32'(word * 8);
        s_axi_arlen   = 8'(len);
        s_axi_arburst = 2'b01;
        while (!s_axi_arready) @(negedge clock);
        @(negedge clock);
        s_axi_arvalid = 1'b0;
        beat = 0;
        while (beat <= len) begin
            s_axi_rready = pick_ready();
            if (s_axi_rvalid && s_axi_rready) begin
                check_value("s_axi_rdata", s_axi_rdata, refuse ? 64'd0 : model_word(word + beat));
                check_value("s_axi_rresp", 64'(s_axi_rresp),
                            refuse ? 64'(RESP_DECERR) : 64'(RESP_OKAY));
                check_value("s_axi_rid", 64'(s_axi_rid), 64'(id));
                check_value("s_axi_rlast", 64'(s_axi_rlast), 64'(beat == len));
                beat++;
            end
            @(negedge clock);
        end
        s_axi_rready = 1'b0;
        if (refuse) begin
            model_errs++;
        end
    endtask

    initial begin
        {s_axi_awvalid, s_axi_awid, s_axi_awaddr, s_axi_awlen, s_axi_awburst} = '0;
        {s_axi_wvalid, s_axi_wdata, s_axi_wstrb, s_axi_wlast, s_axi_bready} = '0;
        {s_axi_arvalid, s_axi_arid, s_axi_araddr, s_axi_arlen, s_axi_arburst} = '0;
        s_axi_rready = 1'b0;
        {cfg_awvalid, cfg_awaddr, cfg_wvalid, cfg_wdata, cfg_bready} = '0;
        {cfg_arvalid, cfg_araddr, cfg_rready} = '0;
        reset       = 1'b1;
        lcg_state   = 32'ha00a_242c;
        model_limit = LIMIT_RESET;
        model_wait  = '0;
        model_errs  = 0;
        stall_en    = 1'b0;
        error_count = 0;
        check_count = 0;
        test_errors = 0;
        tests_done  = 0;
        cycle_count = 0;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        // register reset values and readback
        cfg_read(REG_LIMIT, LIMIT_RESET, RESP_OKAY);
        cfg_read(REG_RD_WAIT, 32'd0, RESP_OKAY);
        cfg_read(REG_ERR_COUNT, 32'd0, RESP_OKAY);
        cfg_write(REG_LIMIT, 32'h1234_5678, RESP_OKAY);
        cfg_read(REG_LIMIT, 32'h1234_5678, RESP_OKAY);
        cfg_write(REG_RD_WAIT, 32'hffff_fff5, RESP_OKAY);
        cfg_read(REG_RD_WAIT, 32'h5, RESP_OKAY); // 4-bit field
        cfg_write(REG_LIMIT, LIMIT_RESET, RESP_OKAY);
        cfg_write(REG_RD_WAIT, 32'd0, RESP_OKAY);
        finish_test("register_reset_readback");

        for (int w = 0; w < MEM_WORDS; w += 16) begin
            write_burst(w, 15, 1'b1); // fill, so no byte reads back unknown
        end
        for (int i = 0; i < 8; i++) begin
            burst_word[i] = rand_below(MEM_WORDS - 16);
            burst_len[i]  = rand_below(16);
            write_burst(burst_word[i], burst_len[i], 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            read_burst(burst_word[i], burst_len[i]);
        end
        finish_test("random_bursts");

        cfg_write(REG_ERR_COUNT, 32'd0, RESP_OKAY);
        model_errs  = 0;
        model_limit = MEM_WORDS * 4 - 1;
        cfg_write(REG_LIMIT, model_limit, RESP_OKAY);
        for (int i = 0; i < 6; i++) begin
            burst_word[i] = MEM_WORDS / 2 - 12 + rand_below(16); // straddles the limit
            burst_len[i]  = rand_below(16);
            write_burst(burst_word[i], burst_len[i], 1'b0);
            read_burst(burst_word[i], burst_len[i]);
        end
        model_limit = LIMIT_RESET;
        cfg_write(REG_LIMIT, model_limit, RESP_OKAY);
        for (int i = 0; i < 6; i++) begin
            read_burst(burst_word[i], burst_len[i]);
        end
        cfg_read(REG_ERR_COUNT, 32'(model_errs), RESP_OKAY);
        cfg_write(REG_ERR_COUNT, 32'd0, RESP_OKAY);
        model_errs = 0;
        cfg_read(REG_ERR_COUNT, 32'd0, RESP_OKAY);
        finish_test("limit_refusal");

        stall_en = 1'b1;
        for (int i = 0; i < 6; i++) begin
            model_wait = 4'(1 + rand_below(15));
            cfg_write(REG_RD_WAIT, 32'(model_wait), RESP_OKAY);
            burst_word[i] = rand_below(MEM_WORDS - 16);
            burst_len[i]  = rand_below(16);
            write_burst(burst_word[i], burst_len[i], 1'b0);
            read_burst(burst_word[i], burst_len[i]);
        end
        cfg_read(REG_RD_WAIT, 32'(model_wait), RESP_OKAY);
        stall_en = 1'b0;
        finish_test("wait_states_backpressure");

        model_wait = 4'd3;
        cfg_write(REG_RD_WAIT, 32'(model_wait), RESP_OKAY);
        cfg_write(32'hc, 32'hdead_beef, RESP_SLVERR);
        cfg_read(32'h10, 32'd0, RESP_SLVERR);
        cfg_read(32'hc, 32'd0, RESP_SLVERR);
        cfg_read(REG_LIMIT, model_limit, RESP_OKAY);
        cfg_read(REG_RD_WAIT, 32'(model_wait), RESP_OKAY);
        cfg_read(REG_ERR_COUNT, 32'(model_errs), RESP_OKAY);
        finish_test("unmapped_offset");

        $display("%0d tests, %0d checks, %0d errors", tests_done, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/axi_mem_pkg.sv
logic/axi_mem_array.sv
logic/axi_mem_cfg.sv
logic/axi_mem_write.sv
logic/axi_mem_read.sv
logic/axi_mem_top.sv
test/axi_mem_properties.sv
test/axi_mem_tb.sv
